// File: hdl/mx_pkg.sv
// MX decode package with format constants, vector typedefs and the arbiter state enum
package mx_pkg;

  // Beat and element geometry
  localparam int MX_DATA_W  = 256;
  localparam int MX_ELEM_W  = 8;
  localparam int NUM_LANES  = 8;
  localparam int NUM_GROUPS = 4;
  localparam int FP16_W     = 16;

  // Exponent biases of the three formats involved
  localparam int E4M3_BIAS  = 7;
  localparam int FP16_BIAS  = 15;
  localparam int SCALE_BIAS = 127;

  // FP16 special encodings
  localparam logic [FP16_W-1:0] FP16_QNAN = 16'h7E00;
  localparam logic [FP16_W-1:0] FP16_MAXF = 16'h7BFF;

  // 32 packed E4M3 elements, element 0 in the low byte
  typedef logic [MX_DATA_W-1:0] fp8_beat_t;

  // One shared exponent
  typedef logic [7:0] shared_exp_t;

  // One shared exponent per group, group 0 in the low byte
  typedef logic [NUM_GROUPS*$bits(shared_exp_t)-1:0] exp_vec_t;

  // Eight FP16 lanes, lane 0 in the low half-word
  typedef logic [NUM_LANES*FP16_W-1:0] fp16_group_t;

  // Group index within one beat
  typedef logic [$clog2(NUM_GROUPS)-1:0] grp_idx_t;

  // Decoder ownership
  typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_X    = 2'd1,
    ARB_W    = 2'd2
  } arb_state_e;

endpackage : mx_pkg

// File: hdl/mx_slot_if.sv
// Paired slot interface between a slot buffer and the arbiter
`timescale 1ns/1ps

interface mx_slot_if;

  // Heads of the value and exponent FIFOs and their joint valid
  logic                valid;
  mx_pkg::fp8_beat_t   beat;
  mx_pkg::exp_vec_t    exps;

  // One-cycle pop of both heads
  logic                release_pulse;

  modport provider (
    output valid,
    output beat,
    output exps,
    input  release_pulse
  );

  modport user (
    input  valid,
    input  beat,
    input  exps,
    output release_pulse
  );

endinterface : mx_slot_if

// File: hdl/mx_slot_buffer.sv
// Slot buffer with separate value and exponent FIFOs presenting one paired slot
`timescale 1ns/1ps

module mx_slot_buffer #(
  parameter int unsigned SLOT_DEPTH = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              val_valid_i,
  output logic              val_ready_o,
  input  mx_pkg::fp8_beat_t val_data_i,
  input  logic              exp_valid_i,
  output logic              exp_ready_o,
  input  mx_pkg::exp_vec_t  exp_data_i,
  mx_slot_if.provider       slot
);

  localparam int unsigned PTR_W = $clog2(SLOT_DEPTH);
  localparam int unsigned CNT_W = $clog2(SLOT_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  mx_pkg::fp8_beat_t val_mem [SLOT_DEPTH];
  mx_pkg::exp_vec_t  exp_mem [SLOT_DEPTH];

  ptr_t val_wr_q;
  ptr_t val_rd_q;
  ptr_t exp_wr_q;
  ptr_t exp_rd_q;
  cnt_t val_cnt_q;
  cnt_t exp_cnt_q;

  logic val_push;
  logic exp_push;
  logic pop;

  // Circular pointer advance, depth need not be a power of two
  function automatic ptr_t ptr_next(input ptr_t ptr);
    return (ptr == ptr_t'(SLOT_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign val_ready_o = (val_cnt_q != cnt_t'(SLOT_DEPTH));
  assign exp_ready_o = (exp_cnt_q != cnt_t'(SLOT_DEPTH));

  assign val_push = val_valid_i && val_ready_o;
  assign exp_push = exp_valid_i && exp_ready_o;

  // Both heads leave together
  assign pop = slot.release_pulse;

  assign slot.valid = (val_cnt_q != '0) && (exp_cnt_q != '0);
  assign slot.beat  = val_mem[val_rd_q];
  assign slot.exps  = exp_mem[exp_rd_q];

  always_ff @(posedge clk_i) begin
    if (val_push) begin
      val_mem[val_wr_q] <= val_data_i;
    end
    if (exp_push) begin
      exp_mem[exp_wr_q] <= exp_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      val_wr_q  <= '0;
      val_rd_q  <= '0;
      exp_wr_q  <= '0;
      exp_rd_q  <= '0;
      val_cnt_q <= '0;
      exp_cnt_q <= '0;
    end else begin
      if (val_push) begin
        val_wr_q <= ptr_next(val_wr_q);
      end
      if (exp_push) begin
        exp_wr_q <= ptr_next(exp_wr_q);
      end
      if (pop) begin
        val_rd_q <= ptr_next(val_rd_q);
        exp_rd_q <= ptr_next(exp_rd_q);
      end
      val_cnt_q <= val_cnt_q + cnt_t'(val_push) - cnt_t'(pop);
      exp_cnt_q <= exp_cnt_q + cnt_t'(exp_push) - cnt_t'(pop);
    end
  end

endmodule : mx_slot_buffer

// File: hdl/mx_arbiter.sv
// Arbiter FSM granting the shared decoder to X or W and routing its output groups
`timescale 1ns/1ps

module mx_arbiter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  mx_slot_if.user             x_slot,
  mx_slot_if.user             w_slot,
  // Beat request towards the decoder
  output logic                beat_valid_o,
  input  logic                beat_ready_i,
  output mx_pkg::fp8_beat_t   beat_data_o,
  output mx_pkg::exp_vec_t    beat_exps_o,
  output logic                vector_mode_o,
  // Groups coming back from the decoder
  input  logic                grp_valid_i,
  output logic                grp_ready_o,
  input  mx_pkg::fp16_group_t grp_data_i,
  input  logic                beat_done_i,
  // Routed output streams
  output logic                x_fp16_valid_o,
  input  logic                x_fp16_ready_i,
  output mx_pkg::fp16_group_t x_fp16_data_o,
  output logic                w_fp16_valid_o,
  input  logic                w_fp16_ready_i,
  output mx_pkg::fp16_group_t w_fp16_data_o
);

  mx_pkg::arb_state_e state_q;
  mx_pkg::arb_state_e state_d;

  // Set when W should win the next tie
  logic prefer_w_q;
  // Beat of the current grant already handed to the decoder
  logic issued_q;

  logic grant_x;
  logic grant_w;

  assign grant_x = (state_q == mx_pkg::ARB_X);
  assign grant_w = (state_q == mx_pkg::ARB_W);

  always_comb begin
    state_d = state_q;
    case (state_q)
      mx_pkg::ARB_IDLE: begin
        if (x_slot.valid && (!w_slot.valid || !prefer_w_q)) begin
          state_d = mx_pkg::ARB_X;
        end else if (w_slot.valid) begin
          state_d = mx_pkg::ARB_W;
        end
      end
      mx_pkg::ARB_X,
      mx_pkg::ARB_W: begin
        if (beat_done_i) begin
          state_d = mx_pkg::ARB_IDLE;
        end
      end
      default: state_d = mx_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= mx_pkg::ARB_IDLE;
      prefer_w_q <= 1'b0;
      issued_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Flip priority towards the stream that was not just granted
      if (state_q == mx_pkg::ARB_IDLE && state_d == mx_pkg::ARB_X) begin
        prefer_w_q <= 1'b1;
      end else if (state_q == mx_pkg::ARB_IDLE && state_d == mx_pkg::ARB_W) begin
        prefer_w_q <= 1'b0;
      end
      if (beat_done_i) begin
        issued_q <= 1'b0;
      end else if (beat_valid_o && beat_ready_i) begin
        issued_q <= 1'b1;
      end
    end
  end

  // One request per grant
  assign beat_valid_o  = !issued_q && ((grant_x && x_slot.valid) || (grant_w && w_slot.valid));
  assign beat_data_o   = grant_w ? w_slot.beat : x_slot.beat;
  assign beat_exps_o   = grant_w ? w_slot.exps : x_slot.exps;
  assign vector_mode_o = grant_w;

  // Output routing follows the grant
  assign x_fp16_valid_o = grant_x && grp_valid_i;
  assign w_fp16_valid_o = grant_w && grp_valid_i;
  assign x_fp16_data_o  = grp_data_i;
  assign w_fp16_data_o  = grp_data_i;

  always_comb begin
    grp_ready_o = 1'b0;
    if (grant_x) begin
      grp_ready_o = x_fp16_ready_i;
    end else if (grant_w) begin
      grp_ready_o = w_fp16_ready_i;
    end
  end

  // Slot is popped as its last group leaves
  assign x_slot.release_pulse = grant_x && beat_done_i;
  assign w_slot.release_pulse = grant_w && beat_done_i;

endmodule : mx_arbiter

// File: hdl/mx_fp8_to_fp16.sv
// Combinational E4M3 to FP16 conversion of eight lanes with one shared exponent
`timescale 1ns/1ps

module mx_fp8_to_fp16 (
  input  logic [mx_pkg::NUM_LANES*mx_pkg::MX_ELEM_W-1:0] elems_i,
  input  mx_pkg::shared_exp_t                            scale_i,
  output mx_pkg::fp16_group_t                            lanes_o
);

  localparam int EW = mx_pkg::MX_ELEM_W;
  localparam int HW = mx_pkg::FP16_W;

  logic scale_nan;

  // All-ones shared exponent marks the whole block as NaN
  assign scale_nan = (scale_i == 8'hFF);

  for (genvar i = 0; i < mx_pkg::NUM_LANES; i++) begin : g_lane
    logic [EW-1:0] elem;
    logic          sgn;
    logic [3:0]    e_exp;
    logic [2:0]    e_man;
    int            h_exp;
    logic [HW-1:0] lane;

    assign elem  = elems_i[i*EW +: EW];
    assign sgn   = elem[7];
    assign e_exp = elem[6:3];
    assign e_man = elem[2:0];

    // Rebias element and shared exponent into FP16
    assign h_exp = int'(e_exp) - mx_pkg::E4M3_BIAS
                 + (int'(scale_i) - mx_pkg::SCALE_BIAS) + mx_pkg::FP16_BIAS;

    always_comb begin
      if (scale_nan || (elem[6:0] == 7'h7F)) begin
        lane = mx_pkg::FP16_QNAN;
      end else if (e_exp == 4'd0) begin
        // Zero and subnormals flush to signed zero
        lane = {sgn, {(HW-1){1'b0}}};
      end else if (h_exp >= 31) begin
        lane = {sgn, mx_pkg::FP16_MAXF[HW-2:0]};
      end else if (h_exp <= 0) begin
        lane = {sgn, {(HW-1){1'b0}}};
      end else begin
        lane = {sgn, h_exp[4:0], e_man, 7'b0};
      end
    end

    assign lanes_o[i*HW +: HW] = lane;
  end

endmodule : mx_fp8_to_fp16

// File: hdl/mx_decoder.sv
// Shared MX decoder stepping one beat through four registered FP16 lane groups
`timescale 1ns/1ps

module mx_decoder (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                beat_valid_i,
  output logic                beat_ready_o,
  input  mx_pkg::fp8_beat_t   beat_data_i,
  input  mx_pkg::exp_vec_t    beat_exps_i,
  input  logic                vector_mode_i,
  output logic                grp_valid_o,
  input  logic                grp_ready_i,
  output mx_pkg::fp16_group_t grp_data_o,
  output logic                beat_done_o
);

  localparam int GRP_ELEM_W = mx_pkg::NUM_LANES * mx_pkg::MX_ELEM_W;
  localparam int SCALE_W    = $bits(mx_pkg::shared_exp_t);

  // Captured beat
  mx_pkg::fp8_beat_t   beat_q;
  mx_pkg::exp_vec_t    exps_q;
  logic                vec_q;

  // Group currently held in the output register
  mx_pkg::grp_idx_t    grp_idx_q;
  logic                busy_q;
  mx_pkg::fp16_group_t grp_data_q;

  logic                beat_take;
  logic                grp_take;
  logic                last_grp;

  // Converter input selection
  mx_pkg::fp8_beat_t   sel_beat;
  mx_pkg::exp_vec_t    sel_exps;
  logic                sel_vec;
  mx_pkg::grp_idx_t    sel_idx;
  logic [GRP_ELEM_W-1:0] sel_elems;
  mx_pkg::shared_exp_t sel_scale;
  mx_pkg::fp16_group_t conv_lanes;

  assign beat_ready_o = !busy_q;
  assign beat_take    = beat_valid_i && beat_ready_o;
  assign grp_take     = busy_q && grp_ready_i;
  assign last_grp     = (grp_idx_q == mx_pkg::grp_idx_t'(mx_pkg::NUM_GROUPS - 1));

  assign grp_valid_o = busy_q;
  assign grp_data_o  = grp_data_q;
  assign beat_done_o = grp_take && last_grp;

  // Group 0 comes straight from the request, later groups from the captured beat
  assign sel_beat = busy_q ? beat_q : beat_data_i;
  assign sel_exps = busy_q ? exps_q : beat_exps_i;
  assign sel_vec  = busy_q ? vec_q : vector_mode_i;
  assign sel_idx  = busy_q ? grp_idx_q + 1'b1 : '0;

  assign sel_elems = sel_beat[int'(sel_idx)*GRP_ELEM_W +: GRP_ELEM_W];
  assign sel_scale = sel_vec ? sel_exps[int'(sel_idx)*SCALE_W +: SCALE_W]
                             : sel_exps[SCALE_W-1:0];

  mx_fp8_to_fp16 u_conv (
    .elems_i ( sel_elems  ),
    .scale_i ( sel_scale  ),
    .lanes_o ( conv_lanes )
  );

  always_ff @(posedge clk_i) begin
    if (beat_take) begin
      beat_q <= beat_data_i;
      exps_q <= beat_exps_i;
      vec_q  <= vector_mode_i;
    end
    if (beat_take || (grp_take && !last_grp)) begin
      grp_data_q <= conv_lanes;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      grp_idx_q <= '0;
    end else begin
      if (beat_take) begin
        busy_q    <= 1'b1;
        grp_idx_q <= '0;
      end else if (grp_take) begin
        if (last_grp) begin
          busy_q <= 1'b0;
        end else begin
          grp_idx_q <= grp_idx_q + 1'b1;
        end
      end
    end
  end

endmodule : mx_decoder

// File: hdl/mx_decode_top.sv
// MX input decoder top level with X and W slot buffers, arbiter and shared decoder
`timescale 1ns/1ps

module mx_decode_top #(
  parameter int unsigned SLOT_DEPTH = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // X operand stream, scalar exponent
  input  logic                x_val_valid_i,
  output logic                x_val_ready_o,
  input  mx_pkg::fp8_beat_t   x_val_data_i,
  input  logic                x_exp_valid_i,
  output logic                x_exp_ready_o,
  input  mx_pkg::shared_exp_t x_exp_data_i,
  // W operand stream, exponent vector
  input  logic                w_val_valid_i,
  output logic                w_val_ready_o,
  input  mx_pkg::fp8_beat_t   w_val_data_i,
  input  logic                w_exp_valid_i,
  output logic                w_exp_ready_o,
  input  mx_pkg::exp_vec_t    w_exp_data_i,
  // Decoded FP16 groups
  output logic                x_fp16_valid_o,
  input  logic                x_fp16_ready_i,
  output mx_pkg::fp16_group_t x_fp16_data_o,
  output logic                w_fp16_valid_o,
  input  logic                w_fp16_ready_i,
  output mx_pkg::fp16_group_t w_fp16_data_o
);

  mx_slot_if x_slot ();
  mx_slot_if w_slot ();

  mx_pkg::exp_vec_t    x_exp_ext;

  logic                beat_valid;
  logic                beat_ready;
  mx_pkg::fp8_beat_t   beat_data;
  mx_pkg::exp_vec_t    beat_exps;
  logic                vector_mode;
  logic                grp_valid;
  logic                grp_ready;
  mx_pkg::fp16_group_t grp_data;
  logic                beat_done;

  // Scalar exponent sits in byte 0 of the vector
  assign x_exp_ext = mx_pkg::exp_vec_t'(x_exp_data_i);

  mx_slot_buffer #(
    .SLOT_DEPTH ( SLOT_DEPTH )
  ) u_x_slot (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .val_valid_i ( x_val_valid_i ),
    .val_ready_o ( x_val_ready_o ),
    .val_data_i  ( x_val_data_i  ),
    .exp_valid_i ( x_exp_valid_i ),
    .exp_ready_o ( x_exp_ready_o ),
    .exp_data_i  ( x_exp_ext     ),
    .slot        ( x_slot        )
  );

  mx_slot_buffer #(
    .SLOT_DEPTH ( SLOT_DEPTH )
  ) u_w_slot (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .val_valid_i ( w_val_valid_i ),
    .val_ready_o ( w_val_ready_o ),
    .val_data_i  ( w_val_data_i  ),
    .exp_valid_i ( w_exp_valid_i ),
    .exp_ready_o ( w_exp_ready_o ),
    .exp_data_i  ( w_exp_data_i  ),
    .slot        ( w_slot        )
  );

  mx_arbiter u_arbiter (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .x_slot         ( x_slot         ),
    .w_slot         ( w_slot         ),
    .beat_valid_o   ( beat_valid     ),
    .beat_ready_i   ( beat_ready     ),
    .beat_data_o    ( beat_data      ),
    .beat_exps_o    ( beat_exps      ),
    .vector_mode_o  ( vector_mode    ),
    .grp_valid_i    ( grp_valid      ),
    .grp_ready_o    ( grp_ready      ),
    .grp_data_i     ( grp_data       ),
    .beat_done_i    ( beat_done      ),
    .x_fp16_valid_o ( x_fp16_valid_o ),
    .x_fp16_ready_i ( x_fp16_ready_i ),
    .x_fp16_data_o  ( x_fp16_data_o  ),
    .w_fp16_valid_o ( w_fp16_valid_o ),
    .w_fp16_ready_i ( w_fp16_ready_i ),
    .w_fp16_data_o  ( w_fp16_data_o  )
  );

  mx_decoder u_decoder (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .beat_valid_i  ( beat_valid  ),
    .beat_ready_o  ( beat_ready  ),
    .beat_data_i   ( beat_data   ),
    .beat_exps_i   ( beat_exps   ),
    .vector_mode_i ( vector_mode ),
    .grp_valid_o   ( grp_valid   ),
    .grp_ready_i   ( grp_ready   ),
    .grp_data_o    ( grp_data    ),
    .beat_done_o   ( beat_done   )
  );

endmodule : mx_decode_top

// File: test/tb_mx_decode.sv
// Directed testbench for the MX decoder with clock, reset, reference model, checks and watchdog
`timescale 1ns/1ps

module tb_mx_decode;

  // Beats over all tests, sizes the watchdog
  localparam int TOTAL_BEATS     = 31;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 * 20 + 200;

  // Sixteen edge-case E4M3 elements, element 0 in the low byte
  localparam logic [127:0] SPECIAL_ELEMS = 128'h81013FC1_408808FF_7F870580_0038F777;

  logic                clk_i;
  logic                rst_n_i;
  logic                x_val_valid_i;
  logic                x_val_ready_o;
  mx_pkg::fp8_beat_t   x_val_data_i;
  logic                x_exp_valid_i;
  logic                x_exp_ready_o;
  mx_pkg::shared_exp_t x_exp_data_i;
  logic                w_val_valid_i;
  logic                w_val_ready_o;
  mx_pkg::fp8_beat_t   w_val_data_i;
  logic                w_exp_valid_i;
  logic                w_exp_ready_o;
  mx_pkg::exp_vec_t    w_exp_data_i;
  logic                x_fp16_valid_o;
  logic                x_fp16_ready_i;
  mx_pkg::fp16_group_t x_fp16_data_o;
  logic                w_fp16_valid_o;
  logic                w_fp16_ready_i;
  mx_pkg::fp16_group_t w_fp16_data_o;

  // Stimulus of the current test
  mx_pkg::fp8_beat_t   x_val_q[$];
  mx_pkg::shared_exp_t x_exp_q[$];
  mx_pkg::fp8_beat_t   w_val_q[$];
  mx_pkg::exp_vec_t    w_exp_q[$];

  // Expected and received groups per stream
  mx_pkg::fp16_group_t x_exp_grp[$];
  mx_pkg::fp16_group_t w_exp_grp[$];
  mx_pkg::fp16_group_t x_got[$];
  mx_pkg::fp16_group_t w_got[$];

  // Exponents transferred so far in the current test
  int x_exp_sent;
  int w_exp_sent;

  int checks;
  int errors;

  mx_decode_top #(
    .SLOT_DEPTH ( 2 )
  ) DUT (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .x_val_valid_i  ( x_val_valid_i  ),
    .x_val_ready_o  ( x_val_ready_o  ),
    .x_val_data_i   ( x_val_data_i   ),
    .x_exp_valid_i  ( x_exp_valid_i  ),
    .x_exp_ready_o  ( x_exp_ready_o  ),
    .x_exp_data_i   ( x_exp_data_i   ),
    .w_val_valid_i  ( w_val_valid_i  ),
    .w_val_ready_o  ( w_val_ready_o  ),
    .w_val_data_i   ( w_val_data_i   ),
    .w_exp_valid_i  ( w_exp_valid_i  ),
    .w_exp_ready_o  ( w_exp_ready_o  ),
    .w_exp_data_i   ( w_exp_data_i   ),
    .x_fp16_valid_o ( x_fp16_valid_o ),
    .x_fp16_ready_i ( x_fp16_ready_i ),
    .x_fp16_data_o  ( x_fp16_data_o  ),
    .w_fp16_valid_o ( w_fp16_valid_o ),
    .w_fp16_ready_i ( w_fp16_ready_i ),
    .w_fp16_data_o  ( w_fp16_data_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Expected FP16 lane for one E4M3 element and a shared exponent
  function automatic logic [15:0] ref_lane(input logic [7:0] elem, input int scale);
    int exp16;
    if (scale == 255 || elem[6:0] == 7'h7F) begin
      return 16'h7E00;
    end
    if (elem[6:3] == 4'd0) begin
      return {elem[7], 15'h0000};
    end
    exp16 = int'(elem[6:3]) - 7 + (scale - 127) + 15;
    if (exp16 >= 31) begin
      return {elem[7], 15'h7BFF};
    end
    if (exp16 <= 0) begin
      return {elem[7], 15'h0000};
    end
    return {elem[7], exp16[4:0], elem[2:0], 7'h00};
  endfunction

  function automatic mx_pkg::fp16_group_t ref_group(input mx_pkg::fp8_beat_t beat,
                                                    input mx_pkg::exp_vec_t exps,
                                                    input bit vec, input int g);
    mx_pkg::fp16_group_t grp;
    int                  scale;
    scale = vec ? int'(exps[g*8 +: 8]) : int'(exps[7:0]);
    for (int l = 0; l < 8; l++) begin
      grp[l*16 +: 16] = ref_lane(beat[(g*8 + l)*8 +: 8], scale);
    end
    return grp;
  endfunction

  function automatic mx_pkg::fp8_beat_t rand_beat();
    mx_pkg::fp8_beat_t beat;
    for (int i = 0; i < 8; i++) begin
      beat[i*32 +: 32] = $urandom;
    end
    return beat;
  endfunction

  task automatic check_group(input string name, input int idx,
                             input mx_pkg::fp16_group_t expected,
                             input mx_pkg::fp16_group_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s group %0d: expected %h, got %h", name, idx, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic clear_queues();
    x_val_q.delete();
    x_exp_q.delete();
    w_val_q.delete();
    w_exp_q.delete();
    x_exp_grp.delete();
    w_exp_grp.delete();
  endtask

  task automatic add_x_beat(input mx_pkg::fp8_beat_t beat, input mx_pkg::shared_exp_t scale);
    x_val_q.push_back(beat);
    x_exp_q.push_back(scale);
    for (int g = 0; g < 4; g++) begin
      x_exp_grp.push_back(ref_group(beat, {24'h0, scale}, 1'b0, g));
    end
  endtask

  task automatic add_w_beat(input mx_pkg::fp8_beat_t beat, input mx_pkg::exp_vec_t exps);
    w_val_q.push_back(beat);
    w_exp_q.push_back(exps);
    for (int g = 0; g < 4; g++) begin
      w_exp_grp.push_back(ref_group(beat, exps, 1'b1, g));
    end
  endtask

  task automatic send_x_vals();
    @(posedge clk_i);
    foreach (x_val_q[i]) begin
      x_val_valid_i <= 1'b1;
      x_val_data_i  <= x_val_q[i];
      do @(negedge clk_i); while (!x_val_ready_o);
      @(posedge clk_i);
    end
    x_val_valid_i <= 1'b0;
  endtask

  task automatic send_x_exps(input int delay);
    repeat (delay + 1) @(posedge clk_i);
    foreach (x_exp_q[i]) begin
      x_exp_valid_i <= 1'b1;
      x_exp_data_i  <= x_exp_q[i];
      do @(negedge clk_i); while (!x_exp_ready_o);
      @(posedge clk_i);
      x_exp_sent++;
    end
    x_exp_valid_i <= 1'b0;
  endtask

  task automatic send_w_vals();
    @(posedge clk_i);
    foreach (w_val_q[i]) begin
      w_val_valid_i <= 1'b1;
      w_val_data_i  <= w_val_q[i];
      do @(negedge clk_i); while (!w_val_ready_o);
      @(posedge clk_i);
    end
    w_val_valid_i <= 1'b0;
  endtask

  task automatic send_w_exps(input int delay);
    repeat (delay + 1) @(posedge clk_i);
    foreach (w_exp_q[i]) begin
      w_exp_valid_i <= 1'b1;
      w_exp_data_i  <= w_exp_q[i];
      do @(negedge clk_i); while (!w_exp_ready_o);
      @(posedge clk_i);
      w_exp_sent++;
    end
    w_exp_valid_i <= 1'b0;
  endtask

  // Accepts groups from both outputs, then watches ten more cycles for extra ones
  task automatic collect_groups(input bit rand_ready);
    int idle;
    idle = 0;
    while (idle < 10) begin
      @(posedge clk_i);
      x_fp16_ready_i <= rand_ready ? 1'($urandom) : 1'b1;
      w_fp16_ready_i <= rand_ready ? 1'($urandom) : 1'b1;
      @(negedge clk_i);
      if (x_fp16_valid_o && x_fp16_ready_i) begin
        if (x_got.size() / 4 >= x_exp_sent) begin
          errors++;
          $display("An X group came out before the exponent of its beat was sent");
        end
        x_got.push_back(x_fp16_data_o);
      end
      if (w_fp16_valid_o && w_fp16_ready_i) begin
        if (w_got.size() / 4 >= w_exp_sent) begin
          errors++;
          $display("A W group came out before the exponent of its beat was sent");
        end
        w_got.push_back(w_fp16_data_o);
      end
      if (x_got.size() >= x_exp_grp.size() && w_got.size() >= w_exp_grp.size()) begin
        idle++;
      end
    end
    @(posedge clk_i);
    x_fp16_ready_i <= 1'b1;
    w_fp16_ready_i <= 1'b1;
  endtask

  // Runs the queued stimulus and compares both output streams in order
  task automatic run_traffic(input int exp_delay, input bit rand_ready);
    x_exp_sent = 0;
    w_exp_sent = 0;
    x_got.delete();
    w_got.delete();
    fork
      send_x_vals();
      send_x_exps(exp_delay);
      send_w_vals();
      send_w_exps(exp_delay);
      collect_groups(rand_ready);
    join
    check_count("x_fp16_valid_o groups", x_exp_grp.size(), x_got.size());
    check_count("w_fp16_valid_o groups", w_exp_grp.size(), w_got.size());
    foreach (x_exp_grp[i]) begin
      if (i < x_got.size()) begin
        check_group("x_fp16_data_o", i, x_exp_grp[i], x_got[i]);
      end
    end
    foreach (w_exp_grp[i]) begin
      if (i < w_got.size()) begin
        check_group("w_fp16_data_o", i, w_exp_grp[i], w_got[i]);
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Test %s finished with %0d errors", name, errors - errors_before);
  endtask

  task automatic test_scalar_exp();
    int e0;
    e0 = errors;
    clear_queues();
    add_x_beat(rand_beat(), 8'd127);
    run_traffic(0, 1'b0);
    report_test("scalar_exp", e0);
  endtask

  task automatic test_vector_exp();
    int e0;
    e0 = errors;
    clear_queues();
    add_w_beat(rand_beat(), {8'd134, 8'd127, 8'd120, 8'd130});
    run_traffic(0, 1'b0);
    report_test("vector_exp", e0);
  endtask

  task automatic test_special_cases();
    int e0;
    e0 = errors;
    clear_queues();
    // Saturation, flush to zero, NaN scale, and plain zeros and NaN elements
    add_x_beat({2{SPECIAL_ELEMS}}, 8'd147);
    add_x_beat({2{SPECIAL_ELEMS}}, 8'd100);
    add_x_beat({2{SPECIAL_ELEMS}}, 8'hFF);
    add_x_beat({2{SPECIAL_ELEMS}}, 8'd127);
    add_w_beat({2{SPECIAL_ELEMS}}, {8'hFF, 8'd100, 8'd147, 8'd127});
    run_traffic(0, 1'b0);
    report_test("special_cases", e0);
  endtask

  task automatic test_interleave();
    int e0;
    e0 = errors;
    clear_queues();
    for (int i = 0; i < 4; i++) begin
      add_x_beat(rand_beat(), 8'($urandom_range(110, 145)));
      add_w_beat(rand_beat(), {8'($urandom_range(110, 145)), 8'($urandom_range(110, 145)),
                               8'($urandom_range(110, 145)), 8'($urandom_range(110, 145))});
    end
    run_traffic(0, 1'b0);
    report_test("interleave", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    clear_queues();
    for (int i = 0; i < 6; i++) begin
      add_x_beat(rand_beat(), 8'($urandom_range(115, 140)));
      add_w_beat(rand_beat(), $urandom);
    end
    run_traffic(0, 1'b1);
    report_test("backpressure", e0);
  endtask

  task automatic test_late_exp();
    int e0;
    e0 = errors;
    clear_queues();
    for (int i = 0; i < 2; i++) begin
      add_x_beat(rand_beat(), 8'($urandom_range(120, 135)));
      add_w_beat(rand_beat(), {8'd125, 8'd129, 8'd131, 8'd127});
    end
    run_traffic(40, 1'b0);
    report_test("late_exp", e0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the DUT stopped producing groups",
             WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(40));
    checks         = 0;
    errors         = 0;
    rst_n_i        = 1'b0;
    x_val_valid_i  = 1'b0;
    x_val_data_i   = '0;
    x_exp_valid_i  = 1'b0;
    x_exp_data_i   = '0;
    w_val_valid_i  = 1'b0;
    w_val_data_i   = '0;
    w_exp_valid_i  = 1'b0;
    w_exp_data_i   = '0;
    x_fp16_ready_i = 1'b1;
    w_fp16_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    test_scalar_exp();
    test_vector_exp();
    test_special_cases();
    test_interleave();
    test_backpressure();
    test_late_exp();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_mx_decode

// File: mx_decode.f
hdl/mx_pkg.sv
hdl/mx_slot_if.sv
hdl/mx_slot_buffer.sv
hdl/mx_arbiter.sv
hdl/mx_fp8_to_fp16.sv
hdl/mx_decoder.sv
hdl/mx_decode_top.sv
test/tb_mx_decode.sv
